// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only -Wall --timing --assert
TOP       ?= tb_cpu
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  := Test failed
PASS_MSG  := Test passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "Simulation did not finish"; exit 1; fi

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: files.f
verilog/cpu_pkg.sv
verilog/hazard_unit.sv
verilog/decode_stage.sv
verilog/execute_stage.sv
verilog/memory_stage.sv
verilog/cpu_top.sv
verif/tb_cpu.sv

// File: verif/tb_cpu.sv
`timescale 1ns/1ps
`default_nettype none

module tb_cpu;

	localparam int ACCEPT_TIMEOUT = 20;
	localparam int DRAIN_TIMEOUT  = 40;
	localparam int WB_LATENCY     = 4;

	// One instruction and what it must produce
	typedef struct {
		cpu_pkg::instr_u          instr;
		bit                       has_wb;
		int                       rd;
		logic [cpu_pkg::XLEN-1:0] data;
		int                       stall_cnt;
	} row_t;

	logic            clk = 1'b0;
	logic            rst_n;
	cpu_pkg::instr_u instr;
	logic            instr_valid;
	logic            stall;
	cpu_pkg::wb_t    wb;

	row_t tbl[$];
	int   wb_rows[$];
	int   acc_cyc[$];
	int   wb_idx = 0;
	int   cyc = 0;

	int value_errs  = 0;
	int stall_errs  = 0;
	int timing_errs = 0;
	int other_errs  = 0;

	cpu_top i_dut (
		.clk         (clk),
		.rst_n       (rst_n),
		.instr       (instr),
		.instr_valid (instr_valid),
		.stall       (stall),
		.wb          (wb)
	);

	always #20 clk = ~clk;

	always @(posedge clk) cyc <= cyc + 1;

	//////////////////////////////////////////////////
	// Encoding and table helpers
	//////////////////////////////////////////////////

	function automatic cpu_pkg::instr_u r_instr(input logic [5:0] op, input int rd,
			input int rs1, input int rs2);
		cpu_pkg::instr_u w;
		w.r_fmt.opcode = op;
		w.r_fmt.rd     = 5'(rd);
		w.r_fmt.rs1    = 5'(rs1);
		w.r_fmt.rs2    = 5'(rs2);
		w.r_fmt.unused = '0;
		return w;
	endfunction

	// For SW the rd argument is the register being stored
	function automatic cpu_pkg::instr_u i_instr(input logic [5:0] op, input int rd,
			input int rs1, input int imm);
		cpu_pkg::instr_u w;
		w.i_fmt.opcode = op;
		w.i_fmt.rd     = 5'(rd);
		w.i_fmt.rs1    = 5'(rs1);
		w.i_fmt.imm    = 16'(imm);
		return w;
	endfunction

	task automatic add_row(input cpu_pkg::instr_u ins, input bit has_wb, input int rd,
			input logic [cpu_pkg::XLEN-1:0] data, input int stall_cnt);
		row_t r;
		r.instr     = ins;
		r.has_wb    = has_wb;
		r.rd        = rd;
		r.data      = data;
		r.stall_cnt = stall_cnt;
		if (has_wb)
			wb_rows.push_back(tbl.size());
		tbl.push_back(r);
	endtask

	// Stalls seen by the next row hold this one in fetch/decode
	function automatic int expected_latency(input int row);
		if (row + 1 < tbl.size())
			return WB_LATENCY + tbl[row + 1].stall_cnt;
		return WB_LATENCY;
	endfunction

	task automatic check_wb(input cpu_pkg::wb_t got, input cpu_pkg::wb_t want);
		if (got.rd !== want.rd) begin
			value_errs++;
			$display("** Error at %0t: wb.rd got %0d expected %0d", $time, got.rd, want.rd);
		end
		if (got.data !== want.data) begin
			value_errs++;
			$display("** Error at %0t: wb.data got %h expected %h", $time, got.data, want.data);
		end
	endtask

	task automatic check_stall(input string what, input int got, input int want);
		if (got != want) begin
			stall_errs++;
			$display("** Error at %0t: stall cycles %s got %0d expected %0d",
				$time, what, got, want);
		end
	endtask

	task automatic check_latency(input int row, input int got, input int want);
		if (got != want) begin
			timing_errs++;
			$display("** Error at %0t: wb.valid latency of row %0d got %0d expected %0d",
				$time, row, got, want);
		end
	endtask

	//////////////////////////////////////////////////
	// Write-back monitor
	//////////////////////////////////////////////////

	always @(negedge clk) begin
		cpu_pkg::wb_t want;
		int           k;
		if (rst_n && wb.valid) begin
			if (wb_idx >= wb_rows.size()) begin
				other_errs++;
				$display("Unexpected write-back to r%0d at %0t", wb.rd, $time);
			end else begin
				k          = wb_rows[wb_idx];
				want.valid = 1'b1;
				want.rd    = 5'(tbl[k].rd);
				want.data  = tbl[k].data;
				check_wb(wb, want);
				check_latency(k, cyc - acc_cyc[k], expected_latency(k));
				wb_idx++;
			end
		end
	end

	//////////////////////////////////////////////////
	// Stimulus
	//////////////////////////////////////////////////

	initial begin
		int stalls;
		int waited;
		bit accepted;
		bit aborted;
		rst_n       = 1'b0;
		instr       = '0;
		instr_valid = 1'b0;
		aborted     = 1'b0;

		// Never-written sources read zero
		add_row(r_instr(cpu_pkg::OP_ADD, 1, 2, 3), 1, 1, 32'd0, 0);
		// ALU rules and a negative immediate
		add_row(i_instr(cpu_pkg::OP_ADDI, 2, 0, 5), 1, 2, 32'd5, 0);
		add_row(i_instr(cpu_pkg::OP_ADDI, 3, 0, -3), 1, 3, 32'hFFFF_FFFD, 0);
		add_row(r_instr(cpu_pkg::OP_ADD, 4, 2, 3), 1, 4, 32'd2, 0);
		add_row(r_instr(cpu_pkg::OP_SUB, 5, 2, 3), 1, 5, 32'd8, 0);
		add_row(r_instr(cpu_pkg::OP_AND, 6, 2, 3), 1, 6, 32'd5, 0);
		add_row(r_instr(cpu_pkg::OP_OR, 7, 2, 3), 1, 7, 32'hFFFF_FFFD, 0);
		add_row(r_instr(cpu_pkg::OP_XOR, 8, 2, 3), 1, 8, 32'hFFFF_FFF8, 0);
		add_row(r_instr(cpu_pkg::OP_SLT, 9, 3, 2), 1, 9, 32'd1, 0);
		add_row(r_instr(cpu_pkg::OP_SLT, 10, 2, 3), 1, 10, 32'd0, 0);
		// Dependent chain at distance 1 and 2
		add_row(i_instr(cpu_pkg::OP_ADDI, 11, 0, 100), 1, 11, 32'd100, 0);
		add_row(i_instr(cpu_pkg::OP_ADDI, 11, 11, 1), 1, 11, 32'd101, 0);
		add_row(r_instr(cpu_pkg::OP_ADD, 12, 11, 11), 1, 12, 32'd202, 0);
		add_row(r_instr(cpu_pkg::OP_SUB, 13, 12, 11), 1, 13, 32'd101, 0);
		// Store then load, then a load user
		add_row(i_instr(cpu_pkg::OP_SW, 12, 0, 16), 0, 0, 32'd0, 0);
		add_row(i_instr(cpu_pkg::OP_LW, 14, 0, 16), 1, 14, 32'd202, 0);
		add_row(r_instr(cpu_pkg::OP_ADD, 15, 14, 2), 1, 15, 32'd207, 0);
		// The row after a load user waits out the stall
		add_row(i_instr(cpu_pkg::OP_ADDI, 16, 0, 7), 1, 16, 32'd7, 1);
		add_row(i_instr(cpu_pkg::OP_ADDI, 17, 0, 9), 1, 17, 32'd9, 0);
		add_row(i_instr(cpu_pkg::OP_ADDI, 18, 0, 32), 1, 18, 32'd32, 0);
		add_row(i_instr(cpu_pkg::OP_SW, 5, 18, 4), 0, 0, 32'd0, 0);
		add_row(i_instr(cpu_pkg::OP_LW, 19, 0, 36), 1, 19, 32'd8, 0);
		add_row(r_instr(cpu_pkg::OP_SUB, 20, 2, 19), 1, 20, 32'hFFFF_FFFD, 0);
		add_row(r_instr(cpu_pkg::OP_NOP, 0, 0, 0), 0, 0, 32'd0, 1);
		// Register 0 stays zero
		add_row(i_instr(cpu_pkg::OP_ADDI, 0, 0, 55), 0, 0, 32'd0, 0);
		add_row(r_instr(cpu_pkg::OP_ADD, 21, 0, 0), 1, 21, 32'd0, 0);
		add_row(r_instr(cpu_pkg::OP_ADD, 22, 2, 0), 1, 22, 32'd5, 0);
		add_row(i_instr(cpu_pkg::OP_LW, 0, 0, 16), 0, 0, 32'd0, 0);
		add_row(r_instr(cpu_pkg::OP_ADD, 23, 0, 2), 1, 23, 32'd5, 0);
		add_row(i_instr(cpu_pkg::OP_ADDI, 24, 0, 1), 1, 24, 32'd1, 0);

		repeat (10) @(posedge clk);
		rst_n <= 1'b1;

		// Idle pipeline after reset
		stalls = 0;
		repeat (4) begin
			@(negedge clk);
			if (stall)
				stalls++;
		end
		check_stall("after reset", stalls, 0);
		@(posedge clk);

		for (int i = 0; i < tbl.size() && !aborted; i++) begin
			instr       <= tbl[i].instr;
			instr_valid <= 1'b1;
			stalls   = 0;
			accepted = 1'b0;
			waited   = 0;
			while (!accepted && waited < ACCEPT_TIMEOUT) begin
				@(negedge clk);
				if (stall) begin
					stalls++;
				end else begin
					accepted = 1'b1;
					acc_cyc.push_back(cyc);
				end
				@(posedge clk);
				waited++;
			end
			if (!accepted) begin
				other_errs++;
				aborted = 1'b1;
				$display("Timeout: row %0d was never accepted", i);
			end else begin
				check_stall($sformatf("before row %0d", i), stalls, tbl[i].stall_cnt);
			end
		end
		instr_valid <= 1'b0;

		waited = 0;
		while (wb_idx < wb_rows.size() && waited < DRAIN_TIMEOUT) begin
			@(negedge clk);
			waited++;
		end
		if (wb_idx < wb_rows.size()) begin
			other_errs++;
			$display("Timeout: only %0d of %0d write-backs arrived", wb_idx, wb_rows.size());
		end
		// Room for any stray write-back
		repeat (8) @(posedge clk);

		$display("Errors: wb %0d, stall %0d, latency %0d, other %0d",
			value_errs, stall_errs, timing_errs, other_errs);
		if (value_errs + stall_errs + timing_errs + other_errs == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: verilog/cpu_pkg.sv
`default_nettype none

package cpu_pkg;

	//////////////////////////////////////////////////
	// Widths
	//////////////////////////////////////////////////

	localparam int XLEN        = 32;
	localparam int REG_ADDR_W  = 5;
	localparam int DMEM_ADDR_W = 8;

	// Opcodes, top six bits of the word
	localparam logic [5:0] OP_NOP  = 6'h00;
	localparam logic [5:0] OP_ADD  = 6'h01;
	localparam logic [5:0] OP_SUB  = 6'h02;
	localparam logic [5:0] OP_AND  = 6'h03;
	localparam logic [5:0] OP_OR   = 6'h04;
	localparam logic [5:0] OP_XOR  = 6'h05;
	localparam logic [5:0] OP_SLT  = 6'h06;
	localparam logic [5:0] OP_ADDI = 6'h08;
	localparam logic [5:0] OP_LW   = 6'h10;
	localparam logic [5:0] OP_SW   = 6'h11;

	// ALU function select
	localparam logic [2:0] ALU_ADD = 3'd0;
	localparam logic [2:0] ALU_SUB = 3'd1;
	localparam logic [2:0] ALU_AND = 3'd2;
	localparam logic [2:0] ALU_OR  = 3'd3;
	localparam logic [2:0] ALU_XOR = 3'd4;
	localparam logic [2:0] ALU_SLT = 3'd5;

	// Operand source in execute
	localparam logic [1:0] FWD_REG = 2'd0;
	localparam logic [1:0] FWD_MEM = 2'd1;
	localparam logic [1:0] FWD_WB  = 2'd2;

	//////////////////////////////////////////////////
	// Instruction word
	//////////////////////////////////////////////////

	typedef struct packed {
		logic [5:0]            opcode;
		logic [REG_ADDR_W-1:0] rd;
		logic [REG_ADDR_W-1:0] rs1;
		logic [REG_ADDR_W-1:0] rs2;
		logic [10:0]           unused;
	} r_fmt_t;

	// For SW the rd slot names the register to store
	typedef struct packed {
		logic [5:0]            opcode;
		logic [REG_ADDR_W-1:0] rd;
		logic [REG_ADDR_W-1:0] rs1;
		logic [15:0]           imm;
	} i_fmt_t;

	typedef union packed {
		r_fmt_t r_fmt;
		i_fmt_t i_fmt;
	} instr_u;

	//////////////////////////////////////////////////
	// Pipeline registers
	//////////////////////////////////////////////////

	typedef struct packed {
		logic       reg_write;
		logic       mem_read;
		logic       mem_write;
		logic       use_imm;
		logic       reads_rs1;
		logic       reads_rs2;
		logic [2:0] alu_op;
	} ctrl_t;

	typedef struct packed {
		logic                  valid;
		ctrl_t                 ctrl;
		logic [REG_ADDR_W-1:0] rd;
		logic [REG_ADDR_W-1:0] rs1;
		logic [REG_ADDR_W-1:0] rs2;
		logic [XLEN-1:0]       rs1_val;
		logic [XLEN-1:0]       rs2_val;
		logic [XLEN-1:0]       imm;
	} idex_t;

	typedef struct packed {
		logic                  valid;
		logic                  reg_write;
		logic                  mem_read;
		logic                  mem_write;
		logic [REG_ADDR_W-1:0] rd;
		logic [XLEN-1:0]       alu_result;
		logic [XLEN-1:0]       store_data;
	} exmem_t;

	typedef struct packed {
		logic                  valid;
		logic [REG_ADDR_W-1:0] rd;
		logic [XLEN-1:0]       data;
	} wb_t;

endpackage

`default_nettype wire

// File: verilog/cpu_top.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_top (
	input  wire logic           clk,
	input  wire logic           rst_n,
	input  wire cpu_pkg::instr_u instr,
	input  wire logic           instr_valid,
	output logic                stall,
	output cpu_pkg::wb_t        wb
);

	// Decode to hazard detection
	logic [cpu_pkg::REG_ADDR_W-1:0] id_rs1;
	logic [cpu_pkg::REG_ADDR_W-1:0] id_rs2;
	logic                           id_reads_rs1;
	logic                           id_reads_rs2;

	// Stage registers
	cpu_pkg::idex_t  idex;
	cpu_pkg::exmem_t exmem;

	// Operand selects for execute
	logic [1:0] fwd_a;
	logic [1:0] fwd_b;

	//////////////////////////////////////////////////
	// Pipeline, in stage order
	//////////////////////////////////////////////////

	decode_stage u_decode (
		.clk          (clk),
		.rst_n        (rst_n),
		.instr        (instr),
		.instr_valid  (instr_valid),
		.stall        (stall),
		.rf_write     (wb),
		.id_rs1       (id_rs1),
		.id_rs2       (id_rs2),
		.id_reads_rs1 (id_reads_rs1),
		.id_reads_rs2 (id_reads_rs2),
		.idex         (idex)
	);

	hazard_unit u_hazard (
		.clk          (clk),
		.rst_n        (rst_n),
		.id_rs1       (id_rs1),
		.id_rs2       (id_rs2),
		.id_reads_rs1 (id_reads_rs1),
		.id_reads_rs2 (id_reads_rs2),
		.idex         (idex),
		.exmem        (exmem),
		.memwb        (wb),
		.stall        (stall),
		.fwd_a        (fwd_a),
		.fwd_b        (fwd_b)
	);

	execute_stage u_execute (
		.clk     (clk),
		.rst_n   (rst_n),
		.idex    (idex),
		.fwd_a   (fwd_a),
		.fwd_b   (fwd_b),
		.mem_fwd (exmem),
		.wb_fwd  (wb),
		.exmem   (exmem)
	);

	// Write-back result doubles as the register file write
	memory_stage u_memory (
		.clk   (clk),
		.rst_n (rst_n),
		.exmem (exmem),
		.memwb (wb)
	);

endmodule

`default_nettype wire

// File: verilog/decode_stage.sv
`timescale 1ns/1ps
`default_nettype none

module decode_stage (
	input  wire logic                            clk,
	input  wire logic                            rst_n,
	input  wire cpu_pkg::instr_u                 instr,
	input  wire logic                            instr_valid,
	input  wire logic                            stall,
	input  wire cpu_pkg::wb_t                    rf_write,
	output logic [cpu_pkg::REG_ADDR_W-1:0]       id_rs1,
	output logic [cpu_pkg::REG_ADDR_W-1:0]       id_rs2,
	output logic                                 id_reads_rs1,
	output logic                                 id_reads_rs2,
	output cpu_pkg::idex_t                       idex
);

	cpu_pkg::instr_u if_instr;
	logic            if_valid;
	cpu_pkg::ctrl_t  dec_ctrl;
	logic [cpu_pkg::XLEN-1:0] regs [(1 << cpu_pkg::REG_ADDR_W)];

	// Register read with write-through from write-back
	function automatic logic [cpu_pkg::XLEN-1:0] rf_read(
		input logic [cpu_pkg::REG_ADDR_W-1:0] idx
	);
		if (idx == '0)
			return '0;
		else if (rf_write.valid && rf_write.rd == idx)
			return rf_write.data;
		else
			return regs[idx];
	endfunction

	//////////////////////////////////////////////////
	// Fetch/decode register
	//////////////////////////////////////////////////

	// Holds its word while stalled
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			if_instr <= '0;
			if_valid <= 1'b0;
		end else if (!stall) begin
			if_instr <= instr;
			if_valid <= instr_valid;
		end
	end

	//////////////////////////////////////////////////
	// Decode
	//////////////////////////////////////////////////

	always_comb begin
		dec_ctrl = '0;
		if (if_valid) begin
			case (if_instr.r_fmt.opcode)
				cpu_pkg::OP_ADD, cpu_pkg::OP_SUB, cpu_pkg::OP_AND,
				cpu_pkg::OP_OR, cpu_pkg::OP_XOR, cpu_pkg::OP_SLT: begin
					dec_ctrl.reg_write = 1'b1;
					dec_ctrl.reads_rs1 = 1'b1;
					dec_ctrl.reads_rs2 = 1'b1;
				end
				cpu_pkg::OP_ADDI: begin
					dec_ctrl.reg_write = 1'b1;
					dec_ctrl.reads_rs1 = 1'b1;
					dec_ctrl.use_imm   = 1'b1;
				end
				cpu_pkg::OP_LW: begin
					dec_ctrl.reg_write = 1'b1;
					dec_ctrl.mem_read  = 1'b1;
					dec_ctrl.reads_rs1 = 1'b1;
					dec_ctrl.use_imm   = 1'b1;
				end
				cpu_pkg::OP_SW: begin
					dec_ctrl.mem_write = 1'b1;
					dec_ctrl.reads_rs1 = 1'b1;
					dec_ctrl.reads_rs2 = 1'b1;
					dec_ctrl.use_imm   = 1'b1;
				end
				// NOP and unknown codes act as a bubble
				default: ;
			endcase
			case (if_instr.r_fmt.opcode)
				cpu_pkg::OP_SUB: dec_ctrl.alu_op = cpu_pkg::ALU_SUB;
				cpu_pkg::OP_AND: dec_ctrl.alu_op = cpu_pkg::ALU_AND;
				cpu_pkg::OP_OR:  dec_ctrl.alu_op = cpu_pkg::ALU_OR;
				cpu_pkg::OP_XOR: dec_ctrl.alu_op = cpu_pkg::ALU_XOR;
				cpu_pkg::OP_SLT: dec_ctrl.alu_op = cpu_pkg::ALU_SLT;
				default:         dec_ctrl.alu_op = cpu_pkg::ALU_ADD;
			endcase
		end
	end

	// Store data comes from the rd slot on SW
	assign id_rs1       = if_instr.r_fmt.rs1;
	assign id_rs2       = dec_ctrl.mem_write ? if_instr.i_fmt.rd : if_instr.r_fmt.rs2;
	assign id_reads_rs1 = dec_ctrl.reads_rs1;
	assign id_reads_rs2 = dec_ctrl.reads_rs2;

	//////////////////////////////////////////////////
	// Register file, r0 never written
	//////////////////////////////////////////////////

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < (1 << cpu_pkg::REG_ADDR_W); i++)
				regs[i] <= '0;
		end else if (rf_write.valid && rf_write.rd != '0) begin
			regs[rf_write.rd] <= rf_write.data;
		end
	end

	// Decode/execute register, bubble on stall
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			idex <= '0;
		end else if (stall) begin
			idex <= '0;
		end else begin
			idex.valid   <= if_valid;
			idex.ctrl    <= dec_ctrl;
			idex.rd      <= if_instr.i_fmt.rd;
			idex.rs1     <= id_rs1;
			idex.rs2     <= id_rs2;
			idex.rs1_val <= rf_read(id_rs1);
			idex.rs2_val <= rf_read(id_rs2);
			idex.imm     <= {{(cpu_pkg::XLEN-16){if_instr.i_fmt.imm[15]}}, if_instr.i_fmt.imm};
		end
	end

endmodule

`default_nettype wire

// File: verilog/execute_stage.sv
`timescale 1ns/1ps
`default_nettype none

module execute_stage (
	input  wire logic             clk,
	input  wire logic             rst_n,
	input  wire cpu_pkg::idex_t   idex,
	input  wire logic [1:0]       fwd_a,
	input  wire logic [1:0]       fwd_b,
	input  wire cpu_pkg::exmem_t  mem_fwd,
	input  wire cpu_pkg::wb_t     wb_fwd,
	output cpu_pkg::exmem_t       exmem
);

	logic [cpu_pkg::XLEN-1:0] op_a;
	logic [cpu_pkg::XLEN-1:0] reg_b;
	logic [cpu_pkg::XLEN-1:0] op_b;
	logic [cpu_pkg::XLEN-1:0] alu_result;

	function automatic logic [cpu_pkg::XLEN-1:0] fwd_mux(
		input logic [1:0]               sel,
		input logic [cpu_pkg::XLEN-1:0] reg_val
	);
		case (sel)
			cpu_pkg::FWD_MEM: return mem_fwd.alu_result;
			cpu_pkg::FWD_WB:  return wb_fwd.data;
			default:          return reg_val;
		endcase
	endfunction

	//////////////////////////////////////////////////
	// Operand select
	//////////////////////////////////////////////////

	assign op_a  = fwd_mux(fwd_a, idex.rs1_val);
	assign reg_b = fwd_mux(fwd_b, idex.rs2_val);

	// ADDI, LW and SW add the immediate
	assign op_b = idex.ctrl.use_imm ? idex.imm : reg_b;

	//////////////////////////////////////////////////
	// ALU
	//////////////////////////////////////////////////

	always_comb begin
		case (idex.ctrl.alu_op)
			cpu_pkg::ALU_SUB: alu_result = op_a - op_b;
			cpu_pkg::ALU_AND: alu_result = op_a & op_b;
			cpu_pkg::ALU_OR:  alu_result = op_a | op_b;
			cpu_pkg::ALU_XOR: alu_result = op_a ^ op_b;
			cpu_pkg::ALU_SLT: begin
				alu_result = {{(cpu_pkg::XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
			end
			default:          alu_result = op_a + op_b;
		endcase
	end

	// Execute/memory register
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			exmem <= '0;
		end else begin
			exmem.valid      <= idex.valid;
			exmem.reg_write  <= idex.valid && idex.ctrl.reg_write;
			exmem.mem_read   <= idex.valid && idex.ctrl.mem_read;
			exmem.mem_write  <= idex.valid && idex.ctrl.mem_write;
			exmem.rd         <= idex.rd;
			exmem.alu_result <= alu_result;
			// Forwarded value, so a store right after its producer is correct
			exmem.store_data <= reg_b;
		end
	end

	// Decoder never issues a load and a store at once
	a_no_read_write: assert property (
		@(posedge clk) disable iff (!rst_n)
		idex.valid |=> !(exmem.mem_read && exmem.mem_write)
	) else $error("load and store set together");

endmodule

`default_nettype wire

// File: verilog/hazard_unit.sv
`timescale 1ns/1ps
`default_nettype none

module hazard_unit (
	input  wire logic                            clk,
	input  wire logic                            rst_n,
	input  wire logic [cpu_pkg::REG_ADDR_W-1:0]  id_rs1,
	input  wire logic [cpu_pkg::REG_ADDR_W-1:0]  id_rs2,
	input  wire logic                            id_reads_rs1,
	input  wire logic                            id_reads_rs2,
	input  wire cpu_pkg::idex_t                  idex,
	input  wire cpu_pkg::exmem_t                 exmem,
	input  wire cpu_pkg::wb_t                    memwb,
	output logic                                 stall,
	output logic [1:0]                           fwd_a,
	output logic [1:0]                           fwd_b
);

	logic load_in_ex;

	// Newest producer wins; a load in memory has no data yet
	function automatic logic [1:0] fwd_sel(
		input logic [cpu_pkg::REG_ADDR_W-1:0] src,
		input logic                           reads
	);
		if (!reads)
			return cpu_pkg::FWD_REG;
		if (exmem.valid && exmem.reg_write && !exmem.mem_read &&
		    exmem.rd != '0 && exmem.rd == src)
			return cpu_pkg::FWD_MEM;
		if (memwb.valid && memwb.rd != '0 && memwb.rd == src)
			return cpu_pkg::FWD_WB;
		return cpu_pkg::FWD_REG;
	endfunction

	//////////////////////////////////////////////////
	// Load-use stall
	//////////////////////////////////////////////////

	assign load_in_ex = idex.valid && idex.ctrl.mem_read && idex.rd != '0;

	assign stall = load_in_ex &&
		((id_reads_rs1 && id_rs1 == idex.rd) ||
		 (id_reads_rs2 && id_rs2 == idex.rd));

	// Forwarding into execute
	assign fwd_a = fwd_sel(idex.rs1, idex.valid && idex.ctrl.reads_rs1);
	assign fwd_b = fwd_sel(idex.rs2, idex.valid && idex.ctrl.reads_rs2);

	// The bubble after a stall can never be a load
	a_stall_single: assert property (
		@(posedge clk) disable iff (!rst_n)
		stall |=> !stall
	) else $error("stall held for two cycles");

endmodule

`default_nettype wire

// File: verilog/memory_stage.sv
`timescale 1ns/1ps
`default_nettype none

module memory_stage (
	input  wire logic            clk,
	input  wire logic            rst_n,
	input  wire cpu_pkg::exmem_t exmem,
	output cpu_pkg::wb_t         memwb
);

	logic [cpu_pkg::XLEN-1:0]        dmem [(1 << cpu_pkg::DMEM_ADDR_W)];
	logic [cpu_pkg::DMEM_ADDR_W-1:0] addr;
	logic [cpu_pkg::XLEN-1:0]        rdata;
	logic                            wb_valid;

	//////////////////////////////////////////////////
	// Data memory
	//////////////////////////////////////////////////

	// Word index from the low bits of the sum
	assign addr  = exmem.alu_result[cpu_pkg::DMEM_ADDR_W-1:0];
	assign rdata = dmem[addr];

	always_ff @(posedge clk) begin
		if (exmem.valid && exmem.mem_write)
			dmem[addr] <= exmem.store_data;
	end

	//////////////////////////////////////////////////
	// Memory/write-back register
	//////////////////////////////////////////////////

	// Writes to r0 are dropped here
	assign wb_valid = exmem.valid && exmem.reg_write && exmem.rd != '0;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			memwb <= '0;
		end else begin
			memwb.valid <= wb_valid;
			memwb.rd    <= exmem.rd;
			memwb.data  <= exmem.mem_read ? rdata : exmem.alu_result;
		end
	end

	// An r0 destination never reaches write-back
	a_no_r0_wb: assert property (
		@(posedge clk) disable iff (!rst_n)
		(exmem.valid && exmem.reg_write && exmem.rd == '0) |=> !memwb.valid
	) else $error("write to r0 reached write-back");

endmodule

`default_nettype wire
